/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////
	// Memory sizes
	//////////////////////////////////////////////////
	localparam int imemDepth = 64; // Words, PC bits 7..2
	localparam int dmemDepth = 32; // Words, address bits 6..2

	// Opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;
	localparam logic [5:0] opBeq   = 6'h04;

	// Funct field of R-type
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr  = 6'h25;
	localparam logic [5:0] functSlt = 6'h2a;

	// ALU operations, decode to execute
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr  = 3'd3;
	localparam logic [2:0] aluSlt = 3'd4;

	//////////////////////////////////////////////////
	// Instruction word, two views of the same bits
	//////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

endpackage

`default_nettype wire

/* design/instructionFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instructionFetch (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,        // From load-use detection
	input  logic              pcSel,        // Taken branch in MEM
	input  logic [31:0]       branchTarget,
	input  logic              imemWrite,    // Loading strobe
	input  logic [5:0]        imemAddr,
	input  logic [31:0]       imemData,
	output logic [31:0]       pcPlus4,
	output mipsPkg::instrWord instruction
);
	import mipsPkg::*;

	logic [31:0] pc;
	logic [31:0] pcNext;
	logic [31:0] imem [imemDepth];

	assign pcNext = pc + 32'd4;

	// Program counter
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (pcSel) begin
			pc <= branchTarget; // Redirect wins over stall
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	// Instruction memory, one word per loading cycle
	always_ff @(posedge clk) begin
		if (imemWrite) begin
			imem[imemAddr] <= imemData;
		end
	end

	//////////////////////////////////////////////////
	// IF/ID latch
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || pcSel) begin
			pcPlus4     <= '0;
			instruction <= '0; // Zero word decodes as nop
		end else if (!stall) begin
			pcPlus4     <= pcNext;
			instruction <= imem[pc[7:2]]; // Word index
		end
	end

endmodule

`default_nettype wire

/* design/instructionDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instructionDecode (
	input  logic              clk,
	input  logic              reset,
	input  logic              flush,       // Taken branch
	input  logic [31:0]       pcPlus4,
	input  mipsPkg::instrWord instruction,
	input  logic              wbWrite,     // Write port from MEM/WB
	input  logic [4:0]        wbAddr,
	input  logic [31:0]       wbData,
	output logic              stall,
	output logic              regWriteEn,
	output logic              memToReg,
	output logic              memRead,
	output logic              memWriteEn,
	output logic              branch,
	output logic              aluSrc,
	output logic [2:0]        aluOp,
	output logic [31:0]       pcPlus4Out,
	output logic [31:0]       regA,
	output logic [31:0]       regB,
	output logic [31:0]       immediate,
	output logic [4:0]        rs,
	output logic [4:0]        rt,
	output logic [4:0]        destReg
);
	import mipsPkg::*;

	logic [31:0] regs [32];
	logic        cRegWrite, cMemToReg, cMemRead, cMemWrite, cBranch, cAluSrc, cUseRd;
	logic [2:0]  cAluOp;
	logic [4:0]  srcA, srcB;
	logic [31:0] readA, readB;

	assign srcA = instruction.iType.rs;
	assign srcB = instruction.iType.rt;

	//////////////////////////////////////////////////
	// Main control
	//////////////////////////////////////////////////
	always_comb begin
		cRegWrite = 1'b0;
		cMemToReg = 1'b0;
		cMemRead  = 1'b0;
		cMemWrite = 1'b0;
		cBranch   = 1'b0;
		cAluSrc   = 1'b0;
		cUseRd    = 1'b0;
		cAluOp    = aluAdd;
		case (instruction.rType.opcode)
			opRType: begin
				cRegWrite = 1'b1;
				cUseRd    = 1'b1; // Destination is rd
				case (instruction.rType.funct)
					functAdd: cAluOp = aluAdd;
					functSub: cAluOp = aluSub;
					functAnd: cAluOp = aluAnd;
					functOr:  cAluOp = aluOr;
					functSlt: cAluOp = aluSlt;
					default:  cRegWrite = 1'b0; // Zero word lands here
				endcase
			end
			opAddi: begin
				cRegWrite = 1'b1;
				cAluSrc   = 1'b1;
			end
			opLw: begin
				cRegWrite = 1'b1;
				cMemToReg = 1'b1;
				cMemRead  = 1'b1;
				cAluSrc   = 1'b1; // Base plus offset
			end
			opSw: begin
				cMemWrite = 1'b1;
				cAluSrc   = 1'b1;
			end
			opBeq: begin
				cBranch = 1'b1;
				cAluOp  = aluSub; // Zero flag means equal
			end
			default: ; // Unknown opcode, nop
		endcase
	end

	// Register file
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbAddr != 5'd0) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Read with same-cycle bypass, r0 hardwired
	function automatic logic [31:0] readReg(input logic [4:0] idx);
		if (idx == 5'd0) begin
			return '0;
		end
		if (wbWrite && wbAddr == idx) begin
			return wbData;
		end
		return regs[idx];
	endfunction

	always_comb begin
		readA = readReg(srcA);
		readB = readReg(srcB);
	end

	// Load in ID/EX feeding this instruction
	assign stall = memRead && (rt == srcA || rt == srcB);

	//////////////////////////////////////////////////
	// ID/EX latch
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || flush || stall) begin
			regWriteEn <= 1'b0; // Bubble
			memToReg   <= 1'b0;
			memRead    <= 1'b0;
			memWriteEn <= 1'b0;
			branch     <= 1'b0;
			aluSrc     <= 1'b0;
			aluOp      <= aluAdd;
		end else begin
			regWriteEn <= cRegWrite;
			memToReg   <= cMemToReg;
			memRead    <= cMemRead;
			memWriteEn <= cMemWrite;
			branch     <= cBranch;
			aluSrc     <= cAluSrc;
			aluOp      <= cAluOp;
		end
	end

	// Payload side
	always_ff @(posedge clk) begin
		pcPlus4Out <= pcPlus4;
		regA       <= readA;
		regB       <= readB;
		immediate  <= {{16{instruction.iType.imm[15]}}, instruction.iType.imm}; // Sign extend
		rs         <= srcA;
		rt         <= srcB;
		destReg    <= cUseRd ? instruction.rType.rd : srcB;
	end

endmodule

`default_nettype wire

/* design/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  logic        clk,
	input  logic        reset,
	input  logic        flush,
	input  logic        regWriteEn,
	input  logic        memToReg,
	input  logic        memRead,
	input  logic        memWriteEn,
	input  logic        branch,
	input  logic        aluSrc,      // Immediate as second operand
	input  logic [2:0]  aluOp,
	input  logic [31:0] pcPlus4,
	input  logic [31:0] regA,
	input  logic [31:0] regB,
	input  logic [31:0] immediate,
	input  logic [4:0]  rs,
	input  logic [4:0]  rt,
	input  logic [4:0]  destReg,
	input  logic        memRegWrite, // EX/MEM, forwarding source
	input  logic [4:0]  memDestReg,
	input  logic [31:0] memResult,
	input  logic        wbWrite,     // MEM/WB, forwarding source
	input  logic [4:0]  wbAddr,
	input  logic [31:0] wbData,
	output logic        regWriteEnOut,
	output logic        memToRegOut,
	output logic        memReadOut,
	output logic        memWriteEnOut,
	output logic        branchOut,
	output logic [31:0] branchTarget,
	output logic [31:0] aluResult,
	output logic        aluZero,
	output logic [31:0] storeData,
	output logic [4:0]  destRegOut
);
	import mipsPkg::*;

	logic [31:0] opA, fwdB, opB, result;

	//////////////////////////////////////////////////
	// Forwarding unit
	//////////////////////////////////////////////////
	function automatic logic [31:0] forward(input logic [4:0] idx, input logic [31:0] value);
		if (idx == 5'd0) begin
			return value; // Register file already gives zero
		end
		if (memRegWrite && memDestReg == idx) begin
			return memResult; // Younger result first
		end
		if (wbWrite && wbAddr == idx) begin
			return wbData;
		end
		return value;
	endfunction

	// Operands and ALU
	always_comb begin
		opA  = forward(rs, regA);
		fwdB = forward(rt, regB);
		opB  = aluSrc ? immediate : fwdB;
		case (aluOp)
			aluAdd:  result = opA + opB;
			aluSub:  result = opA - opB;
			aluAnd:  result = opA & opB;
			aluOr:   result = opA | opB;
			aluSlt:  result = {31'd0, $signed(opA) < $signed(opB)};
			default: result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// EX/MEM latch
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			regWriteEnOut <= 1'b0;
			memToRegOut   <= 1'b0;
			memReadOut    <= 1'b0;
			memWriteEnOut <= 1'b0;
			branchOut     <= 1'b0;
		end else begin
			regWriteEnOut <= regWriteEn;
			memToRegOut   <= memToReg;
			memReadOut    <= memRead;
			memWriteEnOut <= memWriteEn;
			branchOut     <= branch;
		end
	end

	always_ff @(posedge clk) begin
		branchTarget <= pcPlus4 + {immediate[29:0], 2'b00}; // Word offset
		aluResult    <= result;
		aluZero      <= (result == 32'd0);
		storeData    <= fwdB; // Forwarded rt for SW
		destRegOut   <= destReg;
	end

endmodule

`default_nettype wire

/* design/memoryAccess.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryAccess (
	input  logic        clk,
	input  logic        reset,
	input  logic        regWriteEn,
	input  logic        memToReg,
	input  logic        memRead,
	input  logic        memWriteEn,
	input  logic        branch,
	input  logic [31:0] branchTarget,
	input  logic [31:0] aluResult,
	input  logic        aluZero,
	input  logic [31:0] storeData,
	input  logic [4:0]  destReg,
	output logic        pcSel,
	output logic [31:0] branchTargetOut,
	output logic        memRegWrite,
	output logic [4:0]  memDestReg,
	output logic [31:0] memResult,
	output logic        regWrite,     // Committed register write
	output logic [4:0]  regWriteAddr,
	output logic [31:0] regWriteData,
	output logic        memWrite,     // Committed store
	output logic [31:0] memAddr,
	output logic [31:0] memWriteData
);
	import mipsPkg::*;

	logic [31:0] dmem [dmemDepth];
	logic [31:0] loadData, wbAluResult;
	logic        wbMemToReg;

	// Branch decision and forwarding taps
	assign pcSel           = branch && aluZero; // BEQ taken
	assign branchTargetOut = branchTarget;
	assign memRegWrite     = regWriteEn;
	assign memDestReg      = destReg;
	assign memResult       = aluResult;

	// Store strobe straight from EX/MEM
	assign memWrite     = memWriteEn;
	assign memAddr      = aluResult;
	assign memWriteData = storeData;

	// Data memory
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dmemDepth; i++) begin
				dmem[i] <= '0;
			end
		end else if (memWriteEn) begin
			dmem[aluResult[6:2]] <= storeData; // Upper bits ignored
		end
	end

	//////////////////////////////////////////////////
	// MEM/WB latch
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			regWrite <= 1'b0;
		end else begin
			regWrite <= regWriteEn && destReg != 5'd0; // r0 never written
		end
	end

	always_ff @(posedge clk) begin
		regWriteAddr <= destReg;
		wbMemToReg   <= memToReg;
		wbAluResult  <= aluResult;
		if (memRead) begin
			loadData <= dmem[aluResult[6:2]];
		end
	end

	// Write-back select
	assign regWriteData = wbMemToReg ? loadData : wbAluResult;

endmodule

`default_nettype wire

/* design/topLevel.sv */
`timescale 1ns/1ps
`default_nettype none

module topLevel (
	input  logic        clk,
	input  logic        reset,
	input  logic        imemWrite,    // Program loading
	input  logic [5:0]  imemAddr,
	input  logic [31:0] imemData,
	output logic        regWrite,     // Observed register write
	output logic [4:0]  regWriteAddr,
	output logic [31:0] regWriteData,
	output logic        memWrite,     // Observed store
	output logic [31:0] memAddr,
	output logic [31:0] memWriteData
);
	import mipsPkg::*;

	// IF -> ID
	logic [31:0] ifPcPlus4;
	instrWord    instruction;
	// ID -> EX, stall back to IF
	logic        stall, idRegWriteEn, idMemToReg, idMemRead, idMemWriteEn, idBranch, idAluSrc;
	logic [2:0]  idAluOp;
	logic [31:0] idPcPlus4, idRegA, idRegB, idImmediate;
	logic [4:0]  idRs, idRt, idDestReg;
	// EX -> MEM
	logic        exRegWriteEn, exMemToReg, exMemRead, exMemWriteEn, exBranch, exAluZero;
	logic [31:0] exBranchTarget, exAluResult, exStoreData;
	logic [4:0]  exDestReg;
	// MEM -> back
	logic        pcSel, memRegWrite;
	logic [31:0] branchTarget, memResult;
	logic [4:0]  memDestReg;

	//////////////////////////////////////////////////
	// Stage chain
	//////////////////////////////////////////////////
	instructionFetch ifetch0 (
		.clk(clk), .reset(reset), .stall(stall), .pcSel(pcSel),
		.branchTarget(branchTarget), .imemWrite(imemWrite), .imemAddr(imemAddr),
		.imemData(imemData), .pcPlus4(ifPcPlus4), .instruction(instruction)
	);

	instructionDecode idecode0 (
		.clk(clk), .reset(reset), .flush(pcSel), .pcPlus4(ifPcPlus4),
		.instruction(instruction), .wbWrite(regWrite), .wbAddr(regWriteAddr),
		.wbData(regWriteData), .stall(stall), .regWriteEn(idRegWriteEn),
		.memToReg(idMemToReg), .memRead(idMemRead), .memWriteEn(idMemWriteEn),
		.branch(idBranch), .aluSrc(idAluSrc), .aluOp(idAluOp), .pcPlus4Out(idPcPlus4),
		.regA(idRegA), .regB(idRegB), .immediate(idImmediate), .rs(idRs), .rt(idRt),
		.destReg(idDestReg)
	);

	execute execute0 (
		.clk(clk), .reset(reset), .flush(pcSel), .regWriteEn(idRegWriteEn),
		.memToReg(idMemToReg), .memRead(idMemRead), .memWriteEn(idMemWriteEn),
		.branch(idBranch), .aluSrc(idAluSrc), .aluOp(idAluOp), .pcPlus4(idPcPlus4),
		.regA(idRegA), .regB(idRegB), .immediate(idImmediate), .rs(idRs), .rt(idRt),
		.destReg(idDestReg), .memRegWrite(memRegWrite), .memDestReg(memDestReg),
		.memResult(memResult), .wbWrite(regWrite), .wbAddr(regWriteAddr),
		.wbData(regWriteData), .regWriteEnOut(exRegWriteEn), .memToRegOut(exMemToReg),
		.memReadOut(exMemRead), .memWriteEnOut(exMemWriteEn), .branchOut(exBranch),
		.branchTarget(exBranchTarget), .aluResult(exAluResult), .aluZero(exAluZero),
		.storeData(exStoreData), .destRegOut(exDestReg)
	);

	memoryAccess memaccess0 (
		.clk(clk), .reset(reset), .regWriteEn(exRegWriteEn), .memToReg(exMemToReg),
		.memRead(exMemRead), .memWriteEn(exMemWriteEn), .branch(exBranch),
		.branchTarget(exBranchTarget), .aluResult(exAluResult), .aluZero(exAluZero),
		.storeData(exStoreData), .destReg(exDestReg), .pcSel(pcSel),
		.branchTargetOut(branchTarget), .memRegWrite(memRegWrite), .memDestReg(memDestReg),
		.memResult(memResult), .regWrite(regWrite), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .memWrite(memWrite), .memAddr(memAddr),
		.memWriteData(memWriteData)
	);

endmodule

`default_nettype wire

/* verification/topLevel_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module topLevel_properties (
	input logic        clk,
	input logic        reset,
	input logic        regWrite,
	input logic [4:0]  regWriteAddr,
	input logic [31:0] regWriteData,
	input logic        memWrite,
	input logic [31:0] memAddr,
	input logic [31:0] memWriteData,
	input logic        pcSel         // Taken branch in MEM
);

	// r0 is never a write target
	writeNotR0: assert property (@(posedge clk) disable iff (reset)
		regWrite |-> regWriteAddr != 5'd0)
		else $error("register write addressed r0");

	// Pipeline quiet once a reset edge has passed
	quietInReset: assert property (@(posedge clk)
		reset |=> !regWrite && !memWrite && !pcSel)
		else $error("strobe high during reset");

	// Store reaches MEM/WB with no register write of its own
	storeNoRegWrite: assert property (@(posedge clk) disable iff (reset)
		memWrite |=> !regWrite)
		else $error("store also wrote a register");

	// Flush clears EX/MEM, so no second redirect
	singleRedirect: assert property (@(posedge clk) disable iff (reset) pcSel |=> !pcSel)
		else $error("branch redirect held for two cycles");

	knownWrite: assert property (@(posedge clk) disable iff (reset)
		regWrite |-> !$isunknown({regWriteAddr, regWriteData}))
		else $error("register write carries unknown bits");

	knownStore: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> !$isunknown({memAddr, memWriteData}))
		else $error("store carries unknown bits");

endmodule

bind topLevel topLevel_properties topLevel_properties_inst (
	.clk(clk), .reset(reset), .regWrite(regWrite), .regWriteAddr(regWriteAddr),
	.regWriteData(regWriteData), .memWrite(memWrite), .memAddr(memAddr),
	.memWriteData(memWriteData), .pcSel(pcSel)
);

`default_nettype wire

/* verification/topLevel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module topLevel_tb;
	import mipsPkg::*;

	//////////////////////////////////////////////////
	// Run lengths
	//////////////////////////////////////////////////
	localparam int clkPeriod        = 4;   // ns
	localparam int resetCycles      = 4;   // Extra reset cycles after loading
	localparam int numPrograms      = 3;
	localparam int progLen          = 40;  // Instructions per program
	localparam int settleCycles     = 200; // Budget for all expected events
	localparam int drainCycles      = 8;   // Quiet window after the last event
	localparam int cyclesPerProgram = 300; // Load, run and drain, rounded up

	logic        clk;
	logic        reset;
	logic        imemWrite;
	logic [5:0]  imemAddr;
	logic [31:0] imemData;
	logic        regWrite;
	logic [4:0]  regWriteAddr;
	logic [31:0] regWriteData;
	logic        memWrite;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;

	logic [31:0] rngState;
	instrWord    progMem [imemDepth];
	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [dmemDepth];
	logic [4:0]  expWrAddr [$]; // Register writes in program order
	logic [31:0] expWrData [$];
	logic [31:0] expStAddr [$]; // Stores in program order
	logic [31:0] expStData [$];
	int          takenCount;
	int          regErrors;
	int          storeErrors;
	int          otherErrors;

	topLevel topLevel_inst (
		.clk(clk), .reset(reset), .imemWrite(imemWrite), .imemAddr(imemAddr),
		.imemData(imemData), .regWrite(regWrite), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .memWrite(memWrite), .memAddr(memAddr),
		.memWriteData(memWriteData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Watchdog, whole run
	initial begin
		#(numPrograms * cyclesPerProgram * clkPeriod);
		$display("Watchdog expired: run went past %0d cycles", numPrograms * cyclesPerProgram);
		$display("Done: errors found");
		$finish;
	end

	//////////////////////////////////////////////////
	// Random numbers
	//////////////////////////////////////////////////
	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		rngState = nextRandom(rngState);
		return rngState % n;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'(pick(7) + 1); // r1..r7, dense hazards
	endfunction

	function automatic logic [5:0] functFor(input int unsigned k);
		case (k)
			0:       return functAdd;
			1:       return functSub;
			2:       return functAnd;
			3:       return functOr;
			default: return functSlt;
		endcase
	endfunction

	// Program generator
	task automatic buildProgram();
		instrWord    w;
		int unsigned kind;
		for (int i = 0; i < imemDepth; i++) begin
			w = '0; // Tail of memory stays nop
			if (i < progLen) begin
				kind       = pick(10);
				w.iType.rs = pickReg();
				w.iType.rt = pickReg();
				case (kind)
					0, 1, 2, 3, 4: begin
						w.rType.opcode = opRType;
						w.rType.rd     = pickReg();
						w.rType.funct  = functFor(kind);
					end
					5: begin
						w.iType.opcode = opAddi;
						w.iType.imm    = 16'(pick(65536));
					end
					6: begin
						w.iType.opcode = opLw;
						w.iType.imm    = 16'(pick(dmemDepth) * 4); // Word aligned
					end
					7: begin
						w.iType.opcode = opSw;
						w.iType.imm    = 16'(pick(dmemDepth) * 4);
					end
					8: begin
						w.iType.opcode = opBeq;
						if (pick(2) == 0) begin
							w.iType.rt = w.iType.rs; // Forces a taken branch
						end
						w.iType.imm = 16'(pick(4) + 1); // Forward only
					end
					default: begin
						if (pick(2) == 0) begin
							w = '0;
						end else begin
							w = {6'h3f, rngState[25:0]}; // Unknown opcode
						end
					end
				endcase
			end
			progMem[i] = w;
		end
	endtask

	//////////////////////////////////////////////////
	// In-order reference model
	//////////////////////////////////////////////////
	task automatic recordWrite(input logic [4:0] dest, input logic [31:0] value);
		if (dest != 5'd0) begin
			modelRegs[dest] = value;
			expWrAddr.push_back(dest);
			expWrData.push_back(value);
		end
	endtask

	task automatic modelProgram();
		int          pc;
		instrWord    w;
		logic [31:0] a, b, imm, addr;
		pc         = 0;
		takenCount = 0;
		expWrAddr.delete();
		expWrData.delete();
		expStAddr.delete();
		expStData.delete();
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < dmemDepth; i++) begin
			modelMem[i] = '0;
		end
		while (pc < progLen) begin
			w    = progMem[pc];
			a    = modelRegs[w.iType.rs];
			b    = modelRegs[w.iType.rt];
			imm  = {{16{w.iType.imm[15]}}, w.iType.imm};
			addr = a + imm;
			pc++;
			case (w.iType.opcode)
				opRType: begin
					case (w.rType.funct)
						functAdd: recordWrite(w.rType.rd, a + b);
						functSub: recordWrite(w.rType.rd, a - b);
						functAnd: recordWrite(w.rType.rd, a & b);
						functOr:  recordWrite(w.rType.rd, a | b);
						functSlt: recordWrite(w.rType.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default:  ; // Zero word
					endcase
				end
				opAddi: recordWrite(w.iType.rt, addr);
				opLw:   recordWrite(w.iType.rt, modelMem[addr[6:2]]);
				opSw: begin
					modelMem[addr[6:2]] = b;
					expStAddr.push_back(addr);
					expStData.push_back(b);
				end
				opBeq: begin
					if (a == b) begin
						pc = pc + int'($signed(w.iType.imm)); // Skip imm words
						takenCount++;
					end
				end
				default: ;
			endcase
		end
	endtask

	// Load imem with reset held, then release
	task automatic loadProgram();
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < imemDepth; i++) begin
			imemWrite = 1'b1;
			imemAddr  = 6'(i);
			imemData  = progMem[i];
			@(negedge clk);
		end
		imemWrite = 1'b0;
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////
	task automatic checkStrobes();
		logic [4:0]  wantAddr;
		logic [31:0] wantData, wantStAddr, wantStData;
		if (regWrite) begin
			if (expWrAddr.size() == 0) begin
				otherErrors++;
				$display("Unexpected register write to r%0d, none left in the model", regWriteAddr);
			end else begin
				wantAddr = expWrAddr.pop_front();
				wantData = expWrData.pop_front();
				assert (regWriteAddr == wantAddr) else begin
					regErrors++;
					$display("ERR regWriteAddr got %h expected %h", regWriteAddr, wantAddr);
				end
				assert (regWriteData == wantData) else begin
					regErrors++;
					$display("ERR regWriteData got %h expected %h", regWriteData, wantData);
				end
			end
		end
		if (memWrite) begin
			if (expStAddr.size() == 0) begin
				otherErrors++;
				$display("Unexpected store to address %h, none left in the model", memAddr);
			end else begin
				wantStAddr = expStAddr.pop_front();
				wantStData = expStData.pop_front();
				assert (memAddr == wantStAddr) else begin
					storeErrors++;
					$display("ERR memAddr got %h expected %h", memAddr, wantStAddr);
				end
				assert (memWriteData == wantStData) else begin
					storeErrors++;
					$display("ERR memWriteData got %h expected %h", memWriteData, wantStData);
				end
			end
		end
	endtask

	task automatic runProgram(input int progIdx);
		int cycles;
		cycles = 0;
		while ((expWrAddr.size() != 0 || expStAddr.size() != 0) && cycles < settleCycles) begin
			@(negedge clk); // Outputs settled mid cycle
			checkStrobes();
			cycles++;
		end
		if (expWrAddr.size() != 0 || expStAddr.size() != 0) begin
			otherErrors++;
			$display("Program %0d: %0d register writes and %0d stores never appeared",
				progIdx, expWrAddr.size(), expStAddr.size());
		end
		repeat (drainCycles) begin
			@(negedge clk);
			checkStrobes(); // Nothing more may come
		end
	endtask

	// Main sequence
	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		imemWrite   = 1'b0;
		imemAddr    = '0;
		imemData    = '0;
		rngState    = 32'hccb3_8187;
		regErrors   = 0;
		storeErrors = 0;
		otherErrors = 0;
		for (int p = 0; p < numPrograms; p++) begin
			buildProgram();
			modelProgram();
			$display("Program %0d: %0d writes, %0d stores, %0d branches taken",
				p, expWrAddr.size(), expStAddr.size(), takenCount);
			loadProgram();
			runProgram(p);
		end
		$display("Errors: register %0d, store %0d, other %0d", regErrors, storeErrors, otherErrors);
		if (regErrors + storeErrors + otherErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
design/mipsPkg.sv
design/instructionFetch.sv
design/instructionDecode.sv
design/execute.sv
design/memoryAccess.sv
design/topLevel.sv
verification/topLevel_properties.sv
verification/topLevel_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only when the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module topLevel_tb -f filelist.f &&
./obj_dir/VtopLevel_tb | tee /dev/stderr | grep -qxF "Done: no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
